// ==== Bender.yml ====
package:
  name: vm_ctrl

sources:
  - logic/vm_pkg.sv
  - logic/adc_mock.sv
  - logic/seq_acquisition.sv
  - logic/spi_reg_slave.sv
  - logic/pin_output_stage.sv
  - logic/vm_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_vm_top.sv

// ==== logic/adc_mock.sv ====
/*
  stand-in for the converter aperture
  pulses once per arm, needs arm low for a cycle to start again
*/
module adc_mock #(
  parameter int CLK_COUNT_W = 24
) (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic                   arm_i,
  input  logic [CLK_COUNT_W-1:0] clk_count_aperture_i,
  output logic                   measure_valid_o,
  output logic [7:0]             monitor_o
);

  logic [CLK_COUNT_W-1:0] cnt_q;
  logic                   done_q;     // sample taken, waiting for rearm
  logic                   valid_q;
  logic                   toggle_q;   // flips per sample, scope friendly

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      cnt_q    <= '0;
      done_q   <= 1'b0;
      valid_q  <= 1'b0;
      toggle_q <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      if (!arm_i) begin
        cnt_q  <= '0;
        done_q <= 1'b0;
      end else if (!done_q) begin
        if (cnt_q == clk_count_aperture_i) begin   // aperture+1 cycles armed
          valid_q  <= 1'b1;
          done_q   <= 1'b1;
          toggle_q <= ~toggle_q;
        end else begin
          cnt_q <= cnt_q + 1'b1;
        end
      end
    end
  end

  assign measure_valid_o = valid_q;
  assign monitor_o       = {6'b0, toggle_q, arm_i};

  // one sample per arm, never a stretched pulse
  assert property (@(posedge clk) disable iff (!rst_n_i)
    valid_q |=> !valid_q);

endmodule

// ==== logic/pin_output_stage.sv ====
/*
  per-mode pin selection, registered so the isolators see no glitches
  unknown mode codes park every pin low
  outputs lag the selection by one clk
*/
module pin_output_stage (
  input  logic              clk,
  input  logic              rst_n_i,
  input  vm_pkg::mode_e     mode_i,
  input  logic [31:0]       direct_i,
  input  vm_pkg::pin_word_t seq_pins_i,
  output vm_pkg::pin_word_t pins_o
);
  import vm_pkg::*;

  pin_word_t sel;
  pin_word_t pins_q;

  ////////////////////////////////////////
  // mode mux

  always_comb begin
    case (mode_i)
      MODE_DIRECT:   sel = pin_word_t'(direct_i[25:0]);  // bit for bit, top 6 dropped
      MODE_SEQ_MOCK: sel = seq_pins_i;                   // needs trig held high
      default:       sel = '0;                           // parked
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      pins_q <= '0;   // all low out of reset
    end else begin
      pins_q <= sel;
    end
  end

  assign pins_o = pins_q;

endmodule

// ==== logic/seq_acquisition.sv ====
/*
  sequence acquisition against the mock converter
  runs while trig_i is high, drops to idle with index 0 when it falls
  SEQ_MAX must not exceed 4, the words held in the config struct
  config is assumed static while a run is in progress
*/
module seq_acquisition #(
  parameter int CLK_COUNT_W = 24,
  parameter int SEQ_MAX     = 4
) (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              trig_i,
  input  vm_pkg::sa_cfg_t   cfg_i,
  output vm_pkg::pin_word_t pins_o,
  output logic [2:0]        sample_idx_last_o
);
  import vm_pkg::*;

  localparam logic [2:0] SEQ_MAX_L = 3'(SEQ_MAX);

  seq_state_e             state_q;
  logic [2:0]             idx_q;
  logic [2:0]             idx_last_q;
  logic [2:0]             seq_n_eff;
  logic [CLK_COUNT_W-1:0] pc_cnt_q;
  logic [CLK_COUNT_W-1:0] pc_limit;
  logic [CLK_COUNT_W-1:0] ap_limit;
  logic                   adc_arm;
  logic                   adc_valid;
  logic [7:0]             adc_monitor;
  seq_word_t              word;

  assign pc_limit = CLK_COUNT_W'(cfg_i.clk_count_precharge);
  assign ap_limit = CLK_COUNT_W'(cfg_i.clk_count_aperture);

  // 0 acts as 1, clamp to SEQ_MAX
  always_comb begin
    if (cfg_i.seq_n == 3'd0) begin
      seq_n_eff = 3'd1;
    end else if (cfg_i.seq_n > SEQ_MAX_L) begin
      seq_n_eff = SEQ_MAX_L;
    end else begin
      seq_n_eff = cfg_i.seq_n;
    end
  end

  ////////////////////////////////////////
  // fsm

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q    <= SEQ_IDLE;
      idx_q      <= '0;
      idx_last_q <= '0;
      pc_cnt_q   <= '0;
    end else if (!trig_i) begin
      state_q  <= SEQ_IDLE;    // idx_last kept for the status read
      idx_q    <= '0;
      pc_cnt_q <= '0;
    end else begin
      case (state_q)
        SEQ_IDLE: begin
          state_q  <= SEQ_PRECHARGE;
          pc_cnt_q <= '0;
        end
        SEQ_PRECHARGE: begin
          if (pc_cnt_q == pc_limit) begin
            state_q <= SEQ_MEASURE;   // held count+1 cycles
          end else begin
            pc_cnt_q <= pc_cnt_q + 1'b1;
          end
        end
        SEQ_MEASURE: begin
          if (adc_valid) begin
            idx_last_q <= idx_q;
            idx_q      <= (idx_q + 3'd1 >= seq_n_eff) ? 3'd0 : idx_q + 3'd1;
            pc_cnt_q   <= '0;
            state_q    <= SEQ_PRECHARGE;   // arm drops, mock rearms
          end
        end
        default: state_q <= SEQ_IDLE;
      endcase
    end
  end

  assign adc_arm = (state_q == SEQ_MEASURE);
  assign word    = cfg_i.seq[idx_q[1:0]];

  adc_mock #(
    .CLK_COUNT_W(CLK_COUNT_W)
  ) u_adc_mock (
    .clk                 (clk),
    .rst_n_i             (rst_n_i),
    .arm_i               (adc_arm),
    .clk_count_aperture_i(ap_limit),
    .measure_valid_o     (adc_valid),
    .monitor_o           (adc_monitor)
  );

  ////////////////////////////////////////
  // pin fields, rest stay zero

  always_comb begin
    pins_o               = '0;
    pins_o.adc_reset_n   = adc_arm;
    pins_o.meas_complete = adc_valid;
    pins_o.spi_interrupt = adc_valid;    // end of sample to the host
    if (state_q != SEQ_IDLE) begin
      pins_o.pc_sw = word.pc_sw;
      pins_o.azmux = word.azmux;
    end
    pins_o.monitor = {state_q, 1'b0, idx_q, adc_monitor[1:0]};
    pins_o.leds    = {1'b0, idx_q};
  end

  assign sample_idx_last_o = idx_last_q;

  // index tracks the clamped length programmed in the register slave
  assert property (@(posedge clk) disable iff (!rst_n_i)
    idx_q < seq_n_eff);

endmodule

// ==== logic/spi_reg_slave.sv ====
/*
  spi register set, mode 0, msb first, 40-bit frame
  frame = write flag, 7-bit address, 32-bit data
  sck, select and mosi are sampled in the clk domain, so clk must be
  well above 4x sck. a short frame commits nothing
*/
module spi_reg_slave (
  input  logic            clk,
  input  logic            rst_n_i,
  input  logic            spi_sck_i,
  input  logic            spi_cs_n_i,
  input  logic            spi_mosi_i,
  input  logic [31:0]     status_i,
  output logic            spi_miso_o,
  output vm_pkg::mode_e   mode_o,
  output logic [31:0]     direct_o,
  output logic            oe_4094_o,
  output vm_pkg::sa_cfg_t sa_cfg_o
);
  import vm_pkg::*;

  localparam int FRAME_BITS = 40;
  localparam int HDR_BITS   = 8;    // flag + address

  logic [2:0]            sck_q;     // 2 sync stages + edge history
  logic [2:0]            cs_n_q;
  logic [1:0]            mosi_q;
  logic                  sck_rise;
  logic                  sck_fall;
  logic                  cs_rise;
  logic [FRAME_BITS-1:0] shift_q;
  logic [FRAME_BITS-1:0] shift_next;
  logic [5:0]            bit_cnt_q;
  logic [31:0]           rd_shift_q;
  logic [31:0]           rd_word;
  logic                  miso_q;
  logic                  wr_commit;
  reg_addr_e             rd_addr;
  reg_addr_e             wr_addr;
  logic [31:0]           wr_data;

  // register set
  logic [31:0]           mode_q;
  logic [31:0]           direct_q;
  logic [31:0]           oe_q;
  logic [31:0]           precharge_q;
  logic [31:0]           seq_n_q;
  logic [3:0][31:0]      seq_q;
  logic [31:0]           aperture_q;

  ////////////////////////////////////////
  // synchronizers and edges

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      sck_q  <= '0;
      cs_n_q <= '1;   // deselected
      mosi_q <= '0;
    end else begin
      sck_q  <= {sck_q[1:0], spi_sck_i};
      cs_n_q <= {cs_n_q[1:0], spi_cs_n_i};
      mosi_q <= {mosi_q[0], spi_mosi_i};
    end
  end

  assign sck_rise = sck_q[1] & ~sck_q[2];
  assign sck_fall = ~sck_q[1] & sck_q[2];
  assign cs_rise  = cs_n_q[1] & ~cs_n_q[2];

  assign shift_next = {shift_q[FRAME_BITS-2:0], mosi_q[1]};
  assign rd_addr    = reg_addr_e'(shift_next[6:0]);     // valid on the 8th rise
  assign wr_addr    = reg_addr_e'(shift_q[38:32]);
  assign wr_data    = shift_q[31:0];

  // full frame, write flag set, select just released
  assign wr_commit = cs_rise && (bit_cnt_q == 6'(FRAME_BITS)) && shift_q[FRAME_BITS-1];

  ////////////////////////////////////////
  // frame shifter

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      bit_cnt_q <= '0;
      miso_q    <= 1'b0;
    end else if (cs_n_q[1]) begin
      bit_cnt_q <= '0;    // idle between frames
      miso_q    <= 1'b0;
    end else begin
      if (sck_rise && bit_cnt_q != '1) begin
        bit_cnt_q <= bit_cnt_q + 6'd1;   // saturates, long frames never commit
      end
      if (sck_fall && bit_cnt_q >= 6'(HDR_BITS)) begin
        miso_q <= rd_shift_q[31];   // master samples on the next rise
      end
    end
  end

  // payload, no reset
  always_ff @(posedge clk) begin
    if (sck_rise && !cs_n_q[1]) begin
      shift_q <= shift_next;
    end
    if (sck_rise && !cs_n_q[1] && bit_cnt_q == 6'(HDR_BITS - 1)) begin
      rd_shift_q <= shift_next[HDR_BITS-1] ? '0 : rd_word;   // writes shift out zeros
    end else if (sck_fall && bit_cnt_q >= 6'(HDR_BITS)) begin
      rd_shift_q <= {rd_shift_q[30:0], 1'b0};
    end
  end

  ////////////////////////////////////////
  // read mux

  always_comb begin
    case (rd_addr)
      ADDR_MODE:      rd_word = mode_q;
      ADDR_DIRECT:    rd_word = direct_q;
      ADDR_4094_OE:   rd_word = oe_q;
      ADDR_STATUS:    rd_word = status_i;
      ADDR_PRECHARGE: rd_word = precharge_q;
      ADDR_SEQ_N:     rd_word = seq_n_q;
      ADDR_SEQ0:      rd_word = seq_q[0];
      ADDR_SEQ1:      rd_word = seq_q[1];
      ADDR_SEQ2:      rd_word = seq_q[2];
      ADDR_SEQ3:      rd_word = seq_q[3];
      ADDR_APERTURE:  rd_word = aperture_q;
      default:        rd_word = '0;       // unmapped reads as zero
    endcase
  end

  ////////////////////////////////////////
  // register write

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      mode_q      <= '0;   // MODE_DIRECT
      direct_q    <= '0;
      oe_q        <= '0;   // 4094 outputs off at start
      precharge_q <= '0;
      seq_n_q     <= '0;
      seq_q       <= '0;
      aperture_q  <= '0;
    end else if (wr_commit) begin
      case (wr_addr)
        ADDR_MODE:      mode_q      <= wr_data;
        ADDR_DIRECT:    direct_q    <= wr_data;
        ADDR_4094_OE:   oe_q        <= wr_data;
        ADDR_PRECHARGE: precharge_q <= wr_data;
        ADDR_SEQ_N:     seq_n_q     <= wr_data;
        ADDR_SEQ0:      seq_q[0]    <= wr_data;
        ADDR_SEQ1:      seq_q[1]    <= wr_data;
        ADDR_SEQ2:      seq_q[2]    <= wr_data;
        ADDR_SEQ3:      seq_q[3]    <= wr_data;
        ADDR_APERTURE:  aperture_q  <= wr_data;
        default:        ;                      // status and unmapped ignore writes
      endcase
    end
  end

  ////////////////////////////////////////
  // outputs

  assign spi_miso_o = miso_q;
  assign mode_o     = mode_e'(mode_q[2:0]);
  assign direct_o   = direct_q;
  assign oe_4094_o  = oe_q[0];

  always_comb begin
    sa_cfg_o.seq_n = seq_n_q[2:0];
    for (int i = 0; i < 4; i++) begin
      sa_cfg_o.seq[i] = seq_word_t'(seq_q[i][5:0]);
    end
    sa_cfg_o.clk_count_precharge = precharge_q[CFG_COUNT_W-1:0];
    sa_cfg_o.clk_count_aperture  = aperture_q[CFG_COUNT_W-1:0];
  end

  // select pin still high when a write commits
  assert property (@(posedge clk) disable iff (!rst_n_i)
    wr_commit |-> spi_cs_n_i);

endmodule

// ==== logic/vm_pkg.sv ====
/*
  shared types for the voltmeter control fpga
  7-bit register addresses, 32-bit register data
  sequence config holds at most four words; counts are 24 bits wide
  mode codes other than direct and seq mock park every pin low
*/
package vm_pkg;

  ////////////////////////////////////////
  // register map

  typedef enum logic [6:0] {
    ADDR_MODE      = 7'd1,
    ADDR_DIRECT    = 7'd2,
    ADDR_4094_OE   = 7'd3,
    ADDR_STATUS    = 7'd4,   // read only
    ADDR_PRECHARGE = 7'd5,
    ADDR_SEQ_N     = 7'd6,
    ADDR_SEQ0      = 7'd7,
    ADDR_SEQ1      = 7'd8,
    ADDR_SEQ2      = 7'd9,
    ADDR_SEQ3      = 7'd10,
    ADDR_APERTURE  = 7'd11
  } reg_addr_e;

  localparam logic [7:0] STATUS_MAGIC = 8'hAA;   // low byte of status
  localparam int         CFG_COUNT_W  = 24;      // count width held in the config struct

  // alternate function select
  typedef enum logic [2:0] {
    MODE_DIRECT   = 3'd0,
    MODE_SEQ_MOCK = 3'd6
  } mode_e;

  // line encoded chip selects, decimal codes
  typedef enum logic [2:0] {
    CS_NONE       = 3'd0,
    CS_FPGA       = 3'd1,
    CS_4094       = 3'd2,
    CS_INVERT_DAC = 3'd3,
    CS_MDAC1      = 3'd4
  } spi_cs_e;

  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_PRECHARGE,
    SEQ_MEASURE
  } seq_state_e;

  ////////////////////////////////////////
  // structs

  typedef struct packed {
    logic [1:0] pc_sw;    // upper
    logic [3:0] azmux;
  } seq_word_t;

  typedef struct packed {
    logic [2:0]             seq_n;        // 0 acts as 1, capped at 4
    seq_word_t [3:0]        seq;
    logic [CFG_COUNT_W-1:0] clk_count_precharge;
    logic [CFG_COUNT_W-1:0] clk_count_aperture;
  } sa_cfg_t;

  // pin word, same order as the low 26 bits of the direct register
  typedef struct packed {
    logic       adc_reset_n;    // 25
    logic       meas_complete;  // 24
    logic       spi_interrupt;  // 23
    logic       cmpr_latch;     // 22
    logic       sigmux;         // 21
    logic       rstmux;         // 20
    logic [1:0] refmux;         // 19:18
    logic [3:0] azmux;          // 17:14
    logic [1:0] pc_sw;          // 13:12
    logic [7:0] monitor;        // 11:4
    logic [3:0] leds;           // 3:0
  } pin_word_t;

endpackage

// ==== logic/vm_top.sv ====
/*
  voltmeter control fpga, reduced
  one clk domain, spi lines sampled through synchronizers
  only modes 0 (direct) and 6 (sequence with mock adc) drive pins
*/
module vm_top #(
  parameter int CLK_COUNT_W = 24,
  parameter int SEQ_MAX     = 4
) (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              spi_sck_i,
  input  logic              spi_mosi_i,
  input  logic [2:0]        spi_cs_vec_i,
  input  logic [3:0]        hw_flags_i,
  input  logic              sa_trig_i,
  output logic              spi_miso_o,
  output logic              spi_glb_clk_o,
  output logic              spi_glb_mosi_o,
  output logic              spi_4094_strobe_o,
  output logic              spi_4094_oe_o,
  output logic              spi_invert_dac_ss_o,
  output logic              spi_iso_cs_o,
  output logic              spi_iso_cs2_o,
  output vm_pkg::pin_word_t pins_o
);
  import vm_pkg::*;

  spi_cs_e    cs_code;
  logic       reg_cs_n;
  mode_e      mode;
  logic [31:0] direct;
  sa_cfg_t    sa_cfg;
  pin_word_t  seq_pins;
  logic [2:0] sample_idx_last;
  logic [31:0] status;

  ////////////////////////////////////////
  // chip select decode

  assign cs_code = spi_cs_e'(spi_cs_vec_i);

  // shared lines go quiet while the register set is addressed
  assign spi_glb_clk_o       = (cs_code == CS_FPGA) ? 1'b1 : spi_sck_i;   // park hi
  assign spi_glb_mosi_o      = (cs_code == CS_FPGA) ? 1'b1 : spi_mosi_i;  // park hi
  assign reg_cs_n            = (cs_code != CS_FPGA);          // active lo
  assign spi_4094_strobe_o   = (cs_code == CS_4094);          // active hi, park lo
  assign spi_invert_dac_ss_o = (cs_code != CS_INVERT_DAC);    // active lo
  assign spi_iso_cs_o        = (cs_code != CS_MDAC1);         // active lo
  assign spi_iso_cs2_o       = 1'b1;                          // unused select

  // status, msb down
  assign status = {8'h00,
                   1'b0, sa_cfg.seq_n, 1'b0, sample_idx_last,
                   4'b0, hw_flags_i,
                   STATUS_MAGIC};

  spi_reg_slave u_reg (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .spi_sck_i (spi_sck_i),
    .spi_cs_n_i(reg_cs_n),
    .spi_mosi_i(spi_mosi_i),
    .status_i  (status),
    .spi_miso_o(spi_miso_o),
    .mode_o    (mode),
    .direct_o  (direct),
    .oe_4094_o (spi_4094_oe_o),
    .sa_cfg_o  (sa_cfg)
  );

  seq_acquisition #(
    .CLK_COUNT_W(CLK_COUNT_W),
    .SEQ_MAX    (SEQ_MAX)
  ) u_seq (
    .clk              (clk),
    .rst_n_i          (rst_n_i),
    .trig_i           (sa_trig_i),
    .cfg_i            (sa_cfg),
    .pins_o           (seq_pins),
    .sample_idx_last_o(sample_idx_last)
  );

  pin_output_stage u_pins (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .mode_i    (mode),
    .direct_i  (direct),
    .seq_pins_i(seq_pins),
    .pins_o    (pins_o)
  );

endmodule

// ==== project.f ====
+incdir+sim
logic/vm_pkg.sv
logic/adc_mock.sv
logic/seq_acquisition.sv
logic/spi_reg_slave.sv
logic/pin_output_stage.sv
logic/vm_top.sv
sim/tb_vm_top.sv

// ==== sim/tb_spi_host.svh ====
/*
  spi master for the fpga register set, mode 0, msb first, 40-bit frame
  needs clk, spi_sck, spi_mosi, spi_cs_vec, spi_miso and the frame
  constants in the including module. every edge lands on a falling clk
*/

// hold the bus for n falling clk edges
task automatic wait_falling(input int n);
  repeat (n) @(negedge clk);
endtask

// one full frame; rdata holds the last 32 bits seen on miso
task automatic transfer_frame(input logic wr, input logic [6:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
  logic [39:0] frame;
  logic [39:0] captured;
  frame    = {wr, addr, wdata};
  captured = '0;
  @(negedge clk);
  spi_cs_vec = CS_FPGA;               // register set select low
  wait_falling(SCK_HALF);
  for (int i = FRAME_BITS - 1; i >= 0; i--) begin
    spi_mosi = frame[i];              // set up while sck low
    wait_falling(SCK_HALF);
    captured = {captured[38:0], spi_miso};   // slave moved it after the last fall
    spi_sck  = 1'b1;
    wait_falling(SCK_HALF);
    spi_sck  = 1'b0;
  end
  wait_falling(SCK_HALF);
  spi_cs_vec = CS_NONE;               // rising select commits a write
  spi_mosi   = 1'b0;
  wait_falling(FRAME_GAP);
  rdata = captured[31:0];
endtask

task automatic write_register(input logic [6:0] addr, input logic [31:0] data);
  logic [31:0] unused;
  transfer_frame(1'b1, addr, data, unused);
endtask

task automatic read_register(input logic [6:0] addr, output logic [31:0] data);
  transfer_frame(1'b0, addr, 32'h0, data);
endtask

// ==== sim/tb_vm_top.sv ====
/*
  testbench for vm_top, table driven over the spi register set
  spi runs at clk/8, all inputs change on a falling clk edge
  sequence check uses seq_n 3 with short counts against the mock adc
*/
module tb_vm_top;
  import vm_pkg::*;

  localparam int SCK_HALF     = 4;     // clk cycles per sck half period
  localparam int SCK_DIV      = 2 * SCK_HALF;
  localparam int FRAME_BITS   = 40;
  localparam int FRAME_GAP    = 8;     // commit lands within 4
  localparam int FRAME_CYCLES = FRAME_BITS * SCK_DIV + 2 * SCK_HALF + FRAME_GAP + 1;
  localparam int NUM_FRAMES   = 50;
  localparam int TBL_N        = 14;
  localparam int PC_COUNT     = 3;
  localparam int AP_COUNT     = 5;
  localparam int SAMPLES      = 5;
  localparam int SEQ_RUN      = SAMPLES * (PC_COUNT + AP_COUNT + 6);
  // frames plus sequence plus reset and decode steps, doubled for slack
  localparam int TIMEOUT_CYCLES = 2 * (NUM_FRAMES * FRAME_CYCLES + SEQ_RUN + 100);

  typedef struct packed {
    logic [6:0]  addr;
    logic [31:0] wdata;
    logic [31:0] expected;
  } reg_case_t;

  logic        clk;
  logic        rst_n;
  logic        spi_sck;
  logic        spi_mosi;
  logic [2:0]  spi_cs_vec;
  logic [3:0]  hw_flags;
  logic        sa_trig;
  logic        spi_miso;
  logic        spi_glb_clk;
  logic        spi_glb_mosi;
  logic        spi_4094_strobe;
  logic        spi_4094_oe;
  logic        spi_invert_dac_ss;
  logic        spi_iso_cs;
  logic        spi_iso_cs2;
  pin_word_t   pins;
  integer      seed = 32'h6496_c5cd;
  int          err_value;
  int          err_other;
  int          cycle_cnt;
  reg_case_t   table_q [TBL_N];

  vm_top #(
    .CLK_COUNT_W(24),
    .SEQ_MAX    (4)
  ) uut (
    .clk                (clk),
    .rst_n_i            (rst_n),
    .spi_sck_i          (spi_sck),
    .spi_mosi_i         (spi_mosi),
    .spi_cs_vec_i       (spi_cs_vec),
    .hw_flags_i         (hw_flags),
    .sa_trig_i          (sa_trig),
    .spi_miso_o         (spi_miso),
    .spi_glb_clk_o      (spi_glb_clk),
    .spi_glb_mosi_o     (spi_glb_mosi),
    .spi_4094_strobe_o  (spi_4094_strobe),
    .spi_4094_oe_o      (spi_4094_oe),
    .spi_invert_dac_ss_o(spi_invert_dac_ss),
    .spi_iso_cs_o       (spi_iso_cs),
    .spi_iso_cs2_o      (spi_iso_cs2),
    .pins_o             (pins)
  );

  `include "tb_spi_host.svh"

  always #4 clk = ~clk;   // period 8

  ////////////////////////////////////////
  // helpers

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (actual !== expected) begin
      $display("FAILED %s: expected %h, actual %h", name, expected, actual);
      err_value++;
    end
  endtask

  task automatic print_summary();
    $display("errors: %0d wrong values, %0d other", err_value, err_other);
  endtask

  // ten config registers first, then unmapped addresses
  function automatic logic [6:0] table_addr(input int i);
    case (i)
      0:       return ADDR_MODE;
      1:       return ADDR_DIRECT;
      2:       return ADDR_4094_OE;
      3:       return ADDR_PRECHARGE;
      4:       return ADDR_SEQ_N;
      5:       return ADDR_SEQ0;
      6:       return ADDR_SEQ1;
      7:       return ADDR_SEQ2;
      8:       return ADDR_SEQ3;
      9:       return ADDR_APERTURE;
      10:      return 7'd0;
      11:      return 7'd12;
      12:      return 7'd64;
      default: return 7'd127;
    endcase
  endfunction

  // 1..11 without the read-only status
  function automatic logic is_config_reg(input logic [6:0] addr);
    return (addr >= 7'd1) && (addr <= 7'd11) && (addr != 7'd4);
  endfunction

  ////////////////////////////////////////
  // timeout

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout, run still going after %0d clk cycles", cycle_cnt);
      err_other++;
      print_summary();
      $display("test failed");
      $finish;
    end
  end

  ////////////////////////////////////////
  // main sequence

  initial begin
    logic [31:0] rdata;
    logic [31:0] direct_word;
    logic [31:0] expected;
    logic [5:0]  seq_words [3];
    logic [5:0]  cur_word;
    logic [5:0]  prev_word;
    logic [5:0]  cs_expected;
    logic [5:0]  cs_actual;
    int          pulses;
    int          words_seen;
    clk        = 1'b0;
    rst_n      = 1'b0;
    spi_sck    = 1'b0;
    spi_mosi   = 1'b0;
    spi_cs_vec = CS_NONE;
    hw_flags   = 4'h0;
    sa_trig    = 1'b0;
    err_value  = 0;
    err_other  = 0;
    cycle_cnt  = 0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    wait_falling(2);

    // everything low out of reset
    compare_value("reset pins", 32'h0, 32'(pins));
    compare_value("reset 4094 oe", 32'h0, 32'(spi_4094_oe));

    // status: seq_n and last index still 0
    hw_flags = 4'($random(seed));
    expected = {8'h00, 1'b0, 3'd0, 1'b0, 3'd0, 4'h0, hw_flags, STATUS_MAGIC};
    read_register(ADDR_STATUS, rdata);
    compare_value("status after reset", expected, rdata);

    // readback table, all writes before any read
    for (int i = 0; i < TBL_N; i++) begin
      table_q[i].addr     = table_addr(i);
      table_q[i].wdata    = $random(seed);
      table_q[i].expected = is_config_reg(table_q[i].addr) ? table_q[i].wdata : 32'h0;
    end
    for (int i = 0; i < TBL_N; i++) begin
      write_register(table_q[i].addr, table_q[i].wdata);
    end
    for (int i = 0; i < TBL_N; i++) begin
      read_register(table_q[i].addr, rdata);
      compare_value($sformatf("readback addr %0d", table_q[i].addr),
                    table_q[i].expected, rdata);
    end

    // direct mode maps the low 26 bits
    write_register(ADDR_MODE, 32'(MODE_DIRECT));
    direct_word = $random(seed);
    write_register(ADDR_DIRECT, direct_word);
    wait_falling(2);
    compare_value("direct pins", {6'b0, direct_word[25:0]}, 32'(pins));
    for (int m = 1; m < 8; m++) begin
      if (m != 6) begin
        write_register(ADDR_MODE, 32'(m));
        wait_falling(2);
        compare_value($sformatf("parked pins mode %0d", m), 32'h0, 32'(pins));
      end
    end
    write_register(ADDR_MODE, 32'(MODE_DIRECT));

    // 4094 oe follows bit 0 only
    write_register(ADDR_4094_OE, 32'h0000_0001);
    compare_value("4094 oe set", 32'h1, 32'(spi_4094_oe));
    write_register(ADDR_4094_OE, 32'hFFFF_FFFE);
    compare_value("4094 oe clear", 32'h0, 32'(spi_4094_oe));

    // chip select decode, both sck and mosi levels
    for (int p = 0; p < 2; p++) begin
      for (int code = 0; code < 8; code++) begin
        @(negedge clk);
        spi_cs_vec = 3'(code);
        spi_sck    = (p == 1);
        spi_mosi   = (p == 0);
        @(posedge clk);
        cs_expected = {(code == CS_FPGA) ? 1'b1 : spi_sck,
                       (code == CS_FPGA) ? 1'b1 : spi_mosi,
                       code == CS_4094, code != CS_INVERT_DAC,
                       code != CS_MDAC1, 1'b1};
        cs_actual   = {spi_glb_clk, spi_glb_mosi, spi_4094_strobe,
                       spi_invert_dac_ss, spi_iso_cs, spi_iso_cs2};
        compare_value($sformatf("cs decode code %0d sck %0d", code, p),
                      32'(cs_expected), 32'(cs_actual));
      end
    end
    @(negedge clk);
    spi_cs_vec = CS_NONE;
    spi_sck    = 1'b0;
    spi_mosi   = 1'b0;
    wait_falling(FRAME_GAP);

    ////////////////////////////////////////
    // sequence against the mock adc
    seq_words[0] = 6'h13;   // pc_sw 1, azmux 3
    seq_words[1] = 6'h25;
    seq_words[2] = 6'h3A;
    write_register(ADDR_PRECHARGE, 32'(PC_COUNT));
    write_register(ADDR_APERTURE, 32'(AP_COUNT));
    write_register(ADDR_SEQ_N, 32'd3);
    write_register(ADDR_SEQ0, 32'(seq_words[0]));
    write_register(ADDR_SEQ1, 32'(seq_words[1]));
    write_register(ADDR_SEQ2, 32'(seq_words[2]));
    write_register(ADDR_SEQ3, 32'h0000_000F);   // beyond seq_n, never shown
    write_register(ADDR_MODE, 32'(MODE_SEQ_MOCK));
    @(negedge clk);
    sa_trig    = 1'b1;
    pulses     = 0;
    words_seen = 0;
    prev_word  = 6'd0;
    while (pulses < SAMPLES) begin
      @(negedge clk);
      cur_word = {pins.pc_sw, pins.azmux};
      if (cur_word != prev_word && cur_word != 6'd0) begin
        compare_value($sformatf("sequence word %0d", words_seen),
                      32'(seq_words[words_seen % 3]), 32'(cur_word));
        words_seen++;
      end
      prev_word = cur_word;
      if (pins.spi_interrupt) begin
        pulses++;
      end
    end
    sa_trig = 1'b0;
    if (words_seen < 4) begin
      $display("sequence showed only %0d words before %0d samples", words_seen, pulses);
      err_other++;
    end
    wait_falling(4);
    compare_value("idle word after trigger low", 32'h0, 32'({pins.pc_sw, pins.azmux}));
    expected = {8'h00, 1'b0, 3'd3, 1'b0, 3'((pulses - 1) % 3), 4'h0, hw_flags, STATUS_MAGIC};
    read_register(ADDR_STATUS, rdata);
    compare_value("status after sequence", expected, rdata);

    print_summary();
    if (err_value + err_other == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule
